//--- rtl/gat_consts.svh
`ifndef GAT_CONSTS_SVH
`define GAT_CONSTS_SVH

// Feature and subgraph dimensions
`define GAT_FEAT_IN     8
`define GAT_FEAT_OUT    4
`define GAT_MAX_NODES   8

// H stream field widths
`define GAT_DATA_W      8
`define GAT_COL_W       3
`define GAT_ROW_LEN_W   4
`define GAT_NODE_W      4

// Arithmetic widths, sized for the worst case
`define GAT_WH_W        20
`define GAT_COEF_W      32
`define GAT_FEAT_W      56

// Weight address map: W at 0..31, a at 32..35
`define GAT_WADDR_W     6
`define GAT_A_BASE      32

`endif

//--- rtl/gat_pkg.sv
`include "gat_consts.svh"

package gat_pkg;

  typedef logic signed [`GAT_DATA_W-1:0] data_t;
  typedef logic signed [`GAT_WH_W-1:0]   wh_t;
  typedef logic signed [`GAT_COEF_W-1:0] coef_t;
  typedef logic signed [`GAT_FEAT_W-1:0] feat_t;

  // Header word of a node
  typedef struct packed {
    logic [2:0]                rsvd;
    logic [`GAT_ROW_LEN_W-1:0] row_len;
    logic [`GAT_NODE_W-1:0]    num_node;
    logic                      last;
  } h_info_t;

  // Sparse entry word
  typedef struct packed {
    logic                  rsvd;
    logic [`GAT_COL_W-1:0] col_idx;
    data_t                 value;
  } h_entry_t;

  // One 12-bit H word, read as header or entry by the tag
  typedef union packed {
    h_info_t  info;
    h_entry_t entry;
  } h_word_u;

  typedef struct packed {
    data_t [`GAT_FEAT_IN-1:0][`GAT_FEAT_OUT-1:0] w;
    data_t [`GAT_FEAT_OUT-1:0]                   a;
  } wgt_set_t;

  typedef struct packed {
    logic                  ent_vld;
    logic [`GAT_COL_W-1:0] col_idx;
    data_t                 value;
    logic                  row_end;
    logic                  last;
  } h_beat_t;

  typedef wh_t [`GAT_FEAT_OUT-1:0] wh_vec_t;

  typedef struct packed {
    wh_vec_t wh;
    coef_t   coef;
    logic    last;
  } node_res_t;

  typedef feat_t [`GAT_FEAT_OUT-1:0] feat_vec_t;

endpackage

//--- rtl/wgt_store.sv
`timescale 1ns/1ps
`include "gat_consts.svh"

module wgt_store
  import gat_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wgt_we_i,
  input  logic [`GAT_WADDR_W-1:0] wgt_addr_i,
  input  data_t                   wgt_data_i,
  output wgt_set_t                wgt_o
);

  localparam int col_bits = $clog2(`GAT_FEAT_OUT);

  wgt_set_t              wgt_q;
  logic [`GAT_COL_W-1:0] w_row;
  logic [col_bits-1:0]   w_col;
  logic                  in_w;
  logic                  in_a;

  // Row is address / 4, column is address mod 4
  assign w_row = wgt_addr_i[col_bits +: `GAT_COL_W];
  assign w_col = wgt_addr_i[col_bits-1:0];

  assign in_w = (wgt_addr_i < `GAT_A_BASE);
  assign in_a = (wgt_addr_i >= `GAT_A_BASE) &&
                (wgt_addr_i < `GAT_A_BASE + `GAT_FEAT_OUT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wgt_q <= '0;
    end else if (wgt_we_i) begin
      if (in_w) begin
        wgt_q.w[w_row][w_col] <= wgt_data_i;
      end else if (in_a) begin
        // a base is 4-aligned, so the low bits give the element
        wgt_q.a[w_col] <= wgt_data_i;
      end
    end
  end

  assign wgt_o = wgt_q;

endmodule

//--- rtl/h_row_decode.sv
`timescale 1ns/1ps
`include "gat_consts.svh"

module h_row_decode
  import gat_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    h_vld_i,
  input  logic    h_is_info_i,
  input  h_word_u h_word_i,
  output h_beat_t beat_o
);

  h_info_t                   info;
  h_entry_t                  entry;
  logic                      take_info;
  logic                      take_entry;
  logic [`GAT_ROW_LEN_W-1:0] left_q;
  logic                      row_last_q;
  logic                      ent_vld_q;
  logic                      row_end_q;
  logic [`GAT_COL_W-1:0]     col_q;
  data_t                     val_q;

  assign info  = h_word_i.info;
  assign entry = h_word_i.entry;

  assign take_info  = h_vld_i && h_is_info_i;
  // Entries outside an open row are dropped
  assign take_entry = h_vld_i && !h_is_info_i && (left_q != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      left_q     <= '0;
      row_last_q <= 1'b0;
      ent_vld_q  <= 1'b0;
      row_end_q  <= 1'b0;
    end else begin
      ent_vld_q <= take_entry;
      row_end_q <= (take_info && (info.row_len == '0)) ||
                   (take_entry && (left_q == 1));
      if (take_info) begin
        // A new header restarts the row
        left_q     <= info.row_len;
        row_last_q <= info.last;
      end else if (take_entry) begin
        left_q <= left_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_entry) begin
      col_q <= entry.col_idx;
      val_q <= entry.value;
    end
  end

  assign beat_o = '{
    ent_vld: ent_vld_q,
    col_idx: col_q,
    value:   val_q,
    row_end: row_end_q,
    last:    row_last_q
  };

endmodule

//--- rtl/wh_attn_exec.sv
`timescale 1ns/1ps
`include "gat_consts.svh"

module wh_attn_exec
  import gat_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  h_beat_t   beat_i,
  input  wgt_set_t  wgt_i,
  output node_res_t node_o,
  output logic      node_vld_o
);

  wh_vec_t   acc_q;
  wh_vec_t   acc_nxt;
  wh_vec_t   wh_q;
  logic      wh_vld_q;
  logic      wh_last_q;
  coef_t     coef_nxt;
  node_res_t node_q;
  logic      node_vld_q;

  // Entry value times the selected W row
  always_comb begin
    for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
      acc_nxt[k] = acc_q[k];
      if (beat_i.ent_vld) begin
        acc_nxt[k] = acc_q[k] + beat_i.value * wgt_i.w[beat_i.col_idx][k];
      end
    end
  end

  // Attention coefficient of the held WH row
  always_comb begin
    coef_nxt = '0;
    for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
      coef_nxt = coef_nxt + wgt_i.a[k] * wh_q[k];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q      <= '0;
      wh_vld_q   <= 1'b0;
      node_vld_q <= 1'b0;
    end else begin
      // Clear at row end so the next row starts from zero
      if (beat_i.row_end) begin
        acc_q <= '0;
      end else begin
        acc_q <= acc_nxt;
      end
      wh_vld_q   <= beat_i.row_end;
      node_vld_q <= wh_vld_q;
    end
  end

  // Stage 1 holds WH, stage 2 the finished node
  always_ff @(posedge clk) begin
    if (beat_i.row_end) begin
      wh_q      <= acc_nxt;
      wh_last_q <= beat_i.last;
    end
    if (wh_vld_q) begin
      node_q.wh   <= wh_q;
      node_q.coef <= coef_nxt;
      node_q.last <= wh_last_q;
    end
  end

  assign node_o     = node_q;
  assign node_vld_o = node_vld_q;

endmodule

//--- rtl/aggr_result.sv
`timescale 1ns/1ps
`include "gat_consts.svh"

module aggr_result
  import gat_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  node_res_t node_i,
  input  logic      node_vld_i,
  output feat_vec_t feat_o,
  output logic      feat_vld_o
);

  feat_vec_t acc_q;
  feat_vec_t acc_nxt;
  feat_vec_t feat_q;
  logic      feat_vld_q;
  logic      close;

  assign close = node_vld_i && node_i.last;

  // Raw coefficient times WH, no normalization
  always_comb begin
    for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
      acc_nxt[k] = acc_q[k] + node_i.coef * node_i.wh[k];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q      <= '0;
      feat_vld_q <= 1'b0;
    end else begin
      feat_vld_q <= close;
      if (close) begin
        acc_q <= '0;
      end else if (node_vld_i) begin
        acc_q <= acc_nxt;
      end
    end
  end

  // Closing node includes its own term
  always_ff @(posedge clk) begin
    if (close) begin
      feat_q <= acc_nxt;
    end
  end

  assign feat_o     = feat_q;
  assign feat_vld_o = feat_vld_q;

endmodule

//--- rtl/gat_layer_core.sv
`timescale 1ns/1ps
`include "gat_consts.svh"

module gat_layer_core
  import gat_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wgt_we_i,
  input  logic [`GAT_WADDR_W-1:0] wgt_addr_i,
  input  data_t                   wgt_data_i,
  input  logic                    h_vld_i,
  input  logic                    h_is_info_i,
  input  h_word_u                 h_word_i,
  output feat_vec_t               feat_o,
  output logic                    feat_vld_o
);

  wgt_set_t  wgt;
  h_beat_t   beat;
  node_res_t node;
  logic      node_vld;

  wgt_store wgt_store_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wgt_we_i   (wgt_we_i),
    .wgt_addr_i (wgt_addr_i),
    .wgt_data_i (wgt_data_i),
    .wgt_o      (wgt)
  );

  h_row_decode h_row_decode_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .h_vld_i     (h_vld_i),
    .h_is_info_i (h_is_info_i),
    .h_word_i    (h_word_i),
    .beat_o      (beat)
  );

  wh_attn_exec wh_attn_exec_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .beat_i     (beat),
    .wgt_i      (wgt),
    .node_o     (node),
    .node_vld_o (node_vld)
  );

  aggr_result aggr_result_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .node_i     (node),
    .node_vld_i (node_vld),
    .feat_o     (feat_o),
    .feat_vld_o (feat_vld_o)
  );

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

endmodule

//--- test/gat_layer_properties.sv
`timescale 1ns/1ps
`include "gat_consts.svh"

module gat_layer_properties
  import gat_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input logic    h_vld_i,
  input logic    h_is_info_i,
  input h_word_u h_word_i,
  input logic    feat_vld_i
);

  logic [`GAT_ROW_LEN_W-1:0] left_q;
  logic                      last_q;
  logic                      closing;

  // Entries left in the open row, seen from the H stream only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      left_q <= '0;
      last_q <= 1'b0;
    end else if (h_vld_i && h_is_info_i) begin
      left_q <= h_word_i.info.row_len;
      last_q <= h_word_i.info.last;
    end else if (h_vld_i && (left_q != '0)) begin
      left_q <= left_q - 1'b1;
    end
  end

  // Word that ends the last row of a subgraph
  assign closing = h_vld_i && (h_is_info_i ?
                   ((h_word_i.info.row_len == '0) && h_word_i.info.last) :
                   ((left_q == 4'd1) && last_q));

  close_to_feat: assert property (@(posedge clk) disable iff (!rst_n)
    $past(closing, 4) |-> feat_vld_i)
    else $error("feat_vld_o missing 4 cycles after the closing word");

  feat_from_close: assert property (@(posedge clk) disable iff (!rst_n)
    feat_vld_i |-> $past(closing, 4))
    else $error("feat_vld_o pulsed without a closing word 4 cycles before");

  quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !feat_vld_i)
    else $error("feat_vld_o high during reset");

  quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !feat_vld_i)
    else $error("feat_vld_o high on the first cycle after reset");

endmodule

bind gat_layer_core gat_layer_properties gat_layer_properties_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .h_vld_i     (h_vld_i),
  .h_is_info_i (h_is_info_i),
  .h_word_i    (h_word_i),
  .feat_vld_i  (feat_vld_o)
);

//--- test/gat_layer_tb.sv
`timescale 1ns/1ps
`include "gat_consts.svh"

module gat_layer_tb
  import gat_pkg::*;
();

  localparam int timeout_cyc = 300;

  logic                    clk;
  logic                    rst_n;
  logic                    wgt_we_i;
  logic [`GAT_WADDR_W-1:0] wgt_addr_i;
  data_t                   wgt_data_i;
  logic                    h_vld_i;
  logic                    h_is_info_i;
  h_word_u                 h_word_i;
  feat_vec_t               feat_o;
  logic                    feat_vld_o;
  feat_vec_t               exp_feat;
  feat_vec_t               exp_q[$];
  int                      w_m[`GAT_FEAT_IN][`GAT_FEAT_OUT];
  int                      a_m[`GAT_FEAT_OUT];
  longint                  acc_m[`GAT_FEAT_OUT];
  int                      exp_cnt;
  int                      got_cnt;
  int                      chk_cnt;
  int                      err_cnt;
  int                      got_start;
  int                      err_start;

  tb_clk_gen clk_gen_i (.clk_o(clk));

  gat_layer_core gat_layer_core_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .wgt_we_i    (wgt_we_i),
    .wgt_addr_i  (wgt_addr_i),
    .wgt_data_i  (wgt_data_i),
    .h_vld_i     (h_vld_i),
    .h_is_info_i (h_is_info_i),
    .h_word_i    (h_word_i),
    .feat_o      (feat_o),
    .feat_vld_o  (feat_vld_o)
  );

  // Unmapped addresses are written too and must be ignored
  task automatic load_weights(input bit random_vals);
    int v;
    for (int addr = 0; addr < 64; addr++) begin
      if (random_vals) v = int'($urandom_range(255, 0)) - 128;
      else if (addr < `GAT_A_BASE) v = ((addr / 4) % 4 == addr % 4) ? 1 : 0;
      else v = 1;
      @(posedge clk);
      wgt_we_i   <= 1'b1;
      wgt_addr_i <= `GAT_WADDR_W'(addr);
      wgt_data_i <= data_t'(v);
      if (addr < `GAT_A_BASE) w_m[addr / 4][addr % 4] = v;
      else if (addr < `GAT_A_BASE + `GAT_FEAT_OUT) a_m[addr - `GAT_A_BASE] = v;
    end
    @(posedge clk);
    wgt_we_i <= 1'b0;
  endtask

  task automatic send_word(input bit is_info, input h_word_u word, input int gap);
    repeat (gap) begin
      @(posedge clk);
      h_vld_i <= 1'b0;
    end
    @(posedge clk);
    h_vld_i     <= 1'b1;
    h_is_info_i <= is_info;
    h_word_i    <= word;
  endtask

  task automatic send_subgraph(input int nodes, input int gap_max, input bit stray,
                               input bit one_entry);
    h_word_u   word;
    longint    wh[`GAT_FEAT_OUT];
    longint    coef;
    feat_vec_t res;
    int        len;
    int        col;
    int        val;
    for (int n = 0; n < nodes; n++) begin
      // Stray entry between rows that the DUT must drop
      if (stray && ($urandom_range(1, 0) == 1)) begin
        word = '0;
        word.entry.col_idx = `GAT_COL_W'($urandom_range(7, 0));
        word.entry.value = data_t'($urandom_range(255, 0));
        send_word(1'b0, word, 0);
      end
      len = one_entry ? 1 : int'($urandom_range(8, 0));
      word = '0;
      word.info.row_len = `GAT_ROW_LEN_W'(len);
      word.info.num_node = `GAT_NODE_W'(nodes);
      word.info.last = (n == nodes - 1);
      send_word(1'b1, word, int'($urandom_range(gap_max, 0)));
      wh = '{default: 0};
      for (int i = 0; i < len; i++) begin
        col = int'($urandom_range(`GAT_FEAT_IN - 1, 0));
        val = int'($urandom_range(255, 0)) - 128;
        word = '0;
        word.entry.col_idx = `GAT_COL_W'(col);
        word.entry.value = data_t'(val);
        send_word(1'b0, word, int'($urandom_range(gap_max, 0)));
        for (int k = 0; k < `GAT_FEAT_OUT; k++) wh[k] += longint'(val) * w_m[col][k];
      end
      coef = 0;
      for (int k = 0; k < `GAT_FEAT_OUT; k++) coef += a_m[k] * wh[k];
      for (int k = 0; k < `GAT_FEAT_OUT; k++) acc_m[k] += coef * wh[k];
    end
    for (int k = 0; k < `GAT_FEAT_OUT; k++) res[k] = feat_t'(acc_m[k]);
    exp_q.push_back(res);
    exp_cnt++;
    acc_m = '{default: 0};
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    w_m = '{default: 0};
    a_m = '{default: 0};
  endtask

  task automatic finish_run();
    $display("checks: %0d, results: %0d, errors: %0d", chk_cnt, got_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  task automatic close_test(input string name);
    int cyc;
    cyc = 0;
    @(posedge clk);
    h_vld_i <= 1'b0;
    while (got_cnt != exp_cnt && cyc < timeout_cyc) begin
      @(negedge clk);
      cyc++;
    end
    if (got_cnt != exp_cnt) begin
      $display("%s timed out waiting for feat_vld_o", name);
      err_cnt++;
    end
    $display("%s: %0d results, %0d errors", name, got_cnt - got_start, err_cnt - err_start);
    got_start = got_cnt;
    err_start = err_cnt;
  endtask

  // Outputs are stable on the falling edge
  always @(negedge clk) begin
    if (rst_n && feat_vld_o) begin
      assert (exp_q.size() > 0) else begin
        $display("feat_vld_o pulsed with no subgraph pending");
        err_cnt++;
      end
      if (exp_q.size() > 0) begin
        exp_feat = exp_q.pop_front();
        got_cnt++;
        for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
          chk_cnt++;
          assert (feat_o[k] === exp_feat[k]) else begin
            $display("Mismatch feat_o[%0d]: got %h, expected %h", k, feat_o[k], exp_feat[k]);
            err_cnt++;
          end
        end
      end
    end
  end

  initial begin
    rst_n       = 1'b0;
    wgt_we_i    = 1'b0;
    wgt_addr_i  = '0;
    wgt_data_i  = '0;
    h_vld_i     = 1'b0;
    h_is_info_i = 1'b0;
    h_word_i    = '0;
    void'($urandom(32'hc09b));
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    load_weights(1'b0);
    repeat (3) send_subgraph(1, 0, 1'b0, 1'b1);
    close_test("weight loading");

    load_weights(1'b1);
    repeat (6) send_subgraph(int'($urandom_range(4, 1)), 3, 1'b1, 1'b0);
    close_test("sparse decode");

    repeat (10) send_subgraph(int'($urandom_range(8, 1)), 1, 1'b0, 1'b0);
    close_test("aggregation");

    load_weights(1'b1);
    repeat (8) send_subgraph(int'($urandom_range(8, 1)), 0, 1'b0, 1'b0);
    close_test("pipelining");

    // Cleared weights give a zero result
    apply_reset();
    send_subgraph(3, 1, 1'b0, 1'b0);
    close_test("reset");

    finish_run();
  end

endmodule

//--- all.f
+incdir+rtl
rtl/gat_pkg.sv
rtl/wgt_store.sv
rtl/h_row_decode.sv
rtl/wh_attn_exec.sv
rtl/aggr_result.sv
rtl/gat_layer_core.sv
test/tb_clk_gen.sv
test/gat_layer_properties.sv
test/gat_layer_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= gat_layer_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= ALL CHECKS PASSED

SRCS := $(filter-out +%,$(shell cat all.f))
HDRS := $(wildcard rtl/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): all.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f all.f

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
